// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;
	localparam int WORD_BYTES = 4;

	// Top address byte of the private window
	localparam int PRIV_OFFS_W = 24;
	localparam logic [ADDR_W-PRIV_OFFS_W-1:0] PRIV_TAG = '1;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;

	// Native memory request, held by the requester until ready
	typedef struct packed {
		logic valid;
		logic instr;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} mem_req_t;

	// One-cycle ready, read data valid alongside it
	typedef struct packed {
		logic ready;
		data_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: logic/addr_translator.sv
`timescale 1ns/100ps
`default_nettype none

module addr_translator #(
	parameter mem_pkg::addr_t REGION_BASE = 32'h0001_0000
) (
	input wire clk,
	input wire resetn,
	input wire mem_pkg::mem_req_t core_req,
	output mem_pkg::mem_rsp_t core_rsp,
	output mem_pkg::mem_req_t bus_req,
	input wire mem_pkg::mem_rsp_t bus_rsp
);

	logic in_window;
	mem_pkg::addr_t relocated;
	logic answered;

	assign in_window = core_req.addr[mem_pkg::ADDR_W-1:mem_pkg::PRIV_OFFS_W] == mem_pkg::PRIV_TAG;
	assign relocated = REGION_BASE + mem_pkg::addr_t'(core_req.addr[mem_pkg::PRIV_OFFS_W-1:0]);

	// Holds off a second bus access until the core drops valid
	always_ff @(posedge clk) begin
		if (!resetn) begin
			answered <= 1'b0;
		end else if (bus_rsp.ready) begin
			answered <= 1'b1;
		end else if (!core_req.valid) begin
			answered <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		bus_req.instr <= core_req.instr;
		bus_req.addr <= in_window ? relocated : core_req.addr;
		bus_req.wdata <= core_req.wdata;
		if (!resetn) begin
			bus_req.valid <= 1'b0;
			bus_req.wstrb <= '0;
		end else begin
			bus_req.valid <= core_req.valid && !answered && !bus_rsp.ready;
			bus_req.wstrb <= core_req.wstrb;
		end
	end

	always_ff @(posedge clk) begin
		core_rsp.rdata <= bus_rsp.rdata;
		if (!resetn) begin
			core_rsp.ready <= 1'b0;
		end else begin
			core_rsp.ready <= bus_rsp.ready && core_req.valid;
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
	parameter int NUM_CLIENTS = 3
) (
	input wire clk,
	input wire resetn,
	input wire mem_pkg::mem_req_t client_req [NUM_CLIENTS],
	output mem_pkg::mem_rsp_t client_rsp [NUM_CLIENTS],
	output mem_pkg::mem_req_t bus_req,
	input wire mem_pkg::mem_rsp_t bus_rsp
);

	localparam int IDX_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

	logic [NUM_CLIENTS-1:0] valid_q;
	logic [NUM_CLIENTS-1:0] pending;
	logic [NUM_CLIENTS-1:0] instr_vec;
	logic [NUM_CLIENTS-1:0] fetch_pend;
	logic [NUM_CLIENTS-1:0] candidates;
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] owner;
	logic claimed;
	logic served;

	always_comb begin
		for (int idx = 0; idx < NUM_CLIENTS; idx++) begin
			instr_vec[idx] = client_req[idx].instr;
		end
	end

	// Fetches first, then lowest index
	assign fetch_pend = pending & instr_vec;
	assign candidates = (|fetch_pend) ? fetch_pend : pending;

	always_comb begin
		pick = '0;
		for (int idx = NUM_CLIENTS - 1; idx >= 0; idx--) begin
			if (candidates[idx]) begin
				pick = IDX_W'(idx);
			end
		end
	end

	assign served = claimed && bus_rsp.ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_q <= '0;
			pending <= '0;
		end else begin
			for (int idx = 0; idx < NUM_CLIENTS; idx++) begin
				valid_q[idx] <= client_req[idx].valid;
				if (client_req[idx].valid && !valid_q[idx]) begin
					pending[idx] <= 1'b1;
				end else if (!client_req[idx].valid || (served && owner == IDX_W'(idx))) begin
					pending[idx] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			claimed <= 1'b0;
			owner <= '0;
		end else if (claimed) begin
			if (bus_rsp.ready) begin
				claimed <= 1'b0;
			end
		end else if (|pending) begin
			claimed <= 1'b1;
			owner <= pick;
		end
	end

	always_ff @(posedge clk) begin
		bus_req.instr <= client_req[owner].instr;
		bus_req.addr <= client_req[owner].addr;
		bus_req.wdata <= client_req[owner].wdata;
		if (!resetn) begin
			bus_req.valid <= 1'b0;
			bus_req.wstrb <= '0;
		end else if (claimed && !bus_rsp.ready) begin
			bus_req.valid <= 1'b1;
			bus_req.wstrb <= client_req[owner].wstrb;
		end else begin
			bus_req.valid <= 1'b0;
			bus_req.wstrb <= '0;
		end
	end

	// Response goes back to the owner only
	always_ff @(posedge clk) begin
		for (int idx = 0; idx < NUM_CLIENTS; idx++) begin
			if (served && owner == IDX_W'(idx)) begin
				client_rsp[idx].rdata <= bus_rsp.rdata;
			end
			if (!resetn) begin
				client_rsp[idx].ready <= 1'b0;
			end else begin
				client_rsp[idx].ready <= served && owner == IDX_W'(idx);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/block_mover.sv
`timescale 1ns/100ps
`default_nettype none

module block_mover #(
	parameter mem_pkg::addr_t BYTE_COUNT = 32'h0000_0100
) (
	input wire clk,
	input wire resetn,
	input wire start,
	input wire mem_pkg::addr_t src_addr,
	input wire mem_pkg::addr_t dst_addr,
	output logic busy,
	output logic done,
	output mem_pkg::mem_req_t bus_req,
	input wire mem_pkg::mem_rsp_t bus_rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} state_t;

	localparam mem_pkg::addr_t STEP = mem_pkg::addr_t'(mem_pkg::WORD_BYTES);

	state_t state;
	logic start_q;
	mem_pkg::addr_t rd_addr;
	mem_pkg::addr_t wr_addr;
	mem_pkg::addr_t remaining;
	mem_pkg::data_t held_word;

	assign busy = state != ST_IDLE;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_q <= 1'b0;
		end else begin
			start_q <= start;
		end
	end

	always_ff @(posedge clk) begin
		bus_req.instr <= 1'b0;
		if (!resetn) begin
			state <= ST_IDLE;
			remaining <= '0;
			done <= 1'b0;
			bus_req.valid <= 1'b0;
			bus_req.wstrb <= '0;
		end else begin
			done <= 1'b0;
			bus_req.valid <= 1'b0;
			bus_req.wstrb <= '0;
			case (state)
				ST_IDLE: begin
					if (start && !start_q) begin
						rd_addr <= src_addr;
						wr_addr <= dst_addr;
						remaining <= BYTE_COUNT;
						if (BYTE_COUNT == '0) begin
							done <= 1'b1;
						end else begin
							state <= ST_READ;
						end
					end
				end
				ST_READ: begin
					if (bus_rsp.ready) begin
						held_word <= bus_rsp.rdata;
						rd_addr <= rd_addr + STEP;
						state <= ST_WRITE;
					end else begin
						bus_req.valid <= 1'b1;
						bus_req.addr <= rd_addr;
					end
				end
				ST_WRITE: begin
					if (bus_rsp.ready) begin
						wr_addr <= wr_addr + STEP;
						remaining <= remaining - STEP;
						// Last word written
						if (remaining <= STEP) begin
							state <= ST_IDLE;
							done <= 1'b1;
						end else begin
							state <= ST_READ;
						end
					end else begin
						bus_req.valid <= 1'b1;
						bus_req.addr <= wr_addr;
						bus_req.wdata <= held_word;
						bus_req.wstrb <= '1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/copy_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module copy_scheduler #(
	parameter int NUM_PORTS = 2,
	parameter mem_pkg::addr_t PRIV_BASE = 32'h0001_0000,
	parameter mem_pkg::addr_t PRIV_STRIDE = 32'h0001_0000
) (
	input wire clk,
	input wire resetn,
	input wire [NUM_PORTS-1:0] copy_req,
	output logic [NUM_PORTS-1:0] copy_done,
	output logic start,
	output mem_pkg::addr_t src_addr,
	output mem_pkg::addr_t dst_addr,
	input wire busy,
	input wire done
);

	localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [NUM_PORTS-1:0] copy_req_q;
	logic [NUM_PORTS-1:0] pending;
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] served;
	logic launched;
	logic issue;
	mem_pkg::addr_t region_src;
	mem_pkg::addr_t region_dst;

	always_comb begin
		pick = '0;
		for (int idx = NUM_PORTS - 1; idx >= 0; idx--) begin
			if (pending[idx]) begin
				pick = IDX_W'(idx);
			end
		end
	end

	// The last port copies onto its own region
	assign region_src = PRIV_BASE + PRIV_STRIDE * mem_pkg::addr_t'(pick);
	assign region_dst = (pick == IDX_W'(NUM_PORTS - 1)) ? region_src : region_src + PRIV_STRIDE;

	assign issue = (|pending) && !busy && !launched;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			copy_req_q <= '0;
			pending <= '0;
			copy_done <= '0;
		end else begin
			copy_req_q <= copy_req;
			for (int idx = 0; idx < NUM_PORTS; idx++) begin
				if (copy_req[idx] && !copy_req_q[idx]) begin
					pending[idx] <= 1'b1;
				end else if (issue && pick == IDX_W'(idx)) begin
					pending[idx] <= 1'b0;
				end
				if (done && served == IDX_W'(idx)) begin
					copy_done[idx] <= 1'b1;
				end else if (!copy_req[idx]) begin
					copy_done[idx] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			start <= 1'b0;
			launched <= 1'b0;
			served <= '0;
		end else begin
			start <= issue;
			if (issue) begin
				launched <= 1'b1;
				served <= pick;
				src_addr <= region_src;
				dst_addr <= region_dst;
			end else if (done) begin
				launched <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/shared_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module shared_mem_subsys #(
	parameter int NUM_PORTS = 2,
	parameter mem_pkg::addr_t PRIV_BASE = 32'h0001_0000,
	parameter mem_pkg::addr_t PRIV_STRIDE = 32'h0001_0000,
	parameter mem_pkg::addr_t PRIV_LEN = 32'h0000_0100
) (
	input wire clk,
	input wire resetn,
	input wire mem_pkg::mem_req_t port_req [NUM_PORTS],
	output wire mem_pkg::mem_rsp_t port_rsp [NUM_PORTS],
	input wire [NUM_PORTS-1:0] copy_req,
	output wire [NUM_PORTS-1:0] copy_done,
	output wire mem_pkg::mem_req_t mem_req,
	input wire mem_pkg::mem_rsp_t mem_rsp
);

	// Last arbiter slot belongs to the block mover
	wire mem_pkg::mem_req_t xlat_req [NUM_PORTS+1];
	wire mem_pkg::mem_rsp_t xlat_rsp [NUM_PORTS+1];

	wire mover_start;
	wire mem_pkg::addr_t mover_src;
	wire mem_pkg::addr_t mover_dst;
	wire mover_busy;
	wire mover_done;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		addr_translator #(
			.REGION_BASE(PRIV_BASE + PRIV_STRIDE * mem_pkg::addr_t'(i))
		) i_xlat (
			.clk     (clk),
			.resetn  (resetn),
			.core_req(port_req[i]),
			.core_rsp(port_rsp[i]),
			.bus_req (xlat_req[i]),
			.bus_rsp (xlat_rsp[i])
		);
	end

	copy_scheduler #(
		.NUM_PORTS  (NUM_PORTS),
		.PRIV_BASE  (PRIV_BASE),
		.PRIV_STRIDE(PRIV_STRIDE)
	) i_sched (
		.clk      (clk),
		.resetn   (resetn),
		.copy_req (copy_req),
		.copy_done(copy_done),
		.start    (mover_start),
		.src_addr (mover_src),
		.dst_addr (mover_dst),
		.busy     (mover_busy),
		.done     (mover_done)
	);

	block_mover #(
		.BYTE_COUNT(PRIV_LEN)
	) i_mover (
		.clk     (clk),
		.resetn  (resetn),
		.start   (mover_start),
		.src_addr(mover_src),
		.dst_addr(mover_dst),
		.busy    (mover_busy),
		.done    (mover_done),
		.bus_req (xlat_req[NUM_PORTS]),
		.bus_rsp (xlat_rsp[NUM_PORTS])
	);

	mem_arbiter #(
		.NUM_CLIENTS(NUM_PORTS + 1)
	) i_arb (
		.clk       (clk),
		.resetn    (resetn),
		.client_req(xlat_req),
		.client_rsp(xlat_rsp),
		.bus_req   (mem_req),
		.bus_rsp   (mem_rsp)
	);

endmodule

`default_nettype wire

// File: dv/shared_mem_tests.svh
function automatic int word_index(input mem_pkg::addr_t addr);
	return int'(addr[MEM_AW+1:2]);
endfunction

function automatic mem_pkg::data_t merge_bytes(input mem_pkg::data_t old_word,
		input mem_pkg::data_t new_word, input mem_pkg::strb_t strb);
	mem_pkg::data_t merged;
	merged = old_word;
	for (int b = 0; b < mem_pkg::STRB_W; b++) begin
		if (strb[b]) begin
			merged[8*b +: 8] = new_word[8*b +: 8];
		end
	end
	return merged;
endfunction

task automatic start_test(input string name);
	test_name = name;
	test_start_errors = error_count;
	bus_log.delete();
endtask

task automatic close_test();
	tests_run++;
	if (error_count > test_start_errors) begin
		tests_failed++;
		$display("%s: %0d errors", test_name, error_count - test_start_errors);
	end else begin
		$display("%s: ok", test_name);
	end
endtask

task automatic report_problem(input string what);
	error_count++;
	$display("%s: %s", test_name, what);
endtask

task automatic compare_word(input string label, input mem_pkg::data_t expected,
		input mem_pkg::data_t actual);
	if (actual !== expected) begin
		error_count++;
		$display("Fail %s %s: expected %h, actual %h", test_name, label, expected, actual);
	end
endtask

task automatic check_addr(input string label, input mem_pkg::addr_t expected,
		input mem_pkg::addr_t actual);
	if (actual !== expected) begin
		error_count++;
		$display("Fail %s %s: expected %h, actual %h", test_name, label, expected, actual);
	end
endtask

task automatic compare_flag(input string label, input logic expected, input logic actual);
	if (actual !== expected) begin
		error_count++;
		$display("Fail %s %s: expected %b, actual %b", test_name, label, expected, actual);
	end
endtask

// One native access, held until the port's ready pulse
task automatic port_access(input int port, input logic instr, input mem_pkg::addr_t addr,
		input mem_pkg::data_t wdata, input mem_pkg::strb_t wstrb,
		output mem_pkg::data_t rdata);
	mem_pkg::mem_req_t req;
	req.valid = 1'b1;
	req.instr = instr;
	req.addr = addr;
	req.wdata = wdata;
	req.wstrb = wstrb;
	@(posedge clk);
	port_req[port] <= req;
	do @(posedge clk); while (!port_rsp[port].ready);
	rdata = port_rsp[port].rdata;
	port_req[port] <= '0;
endtask

task automatic public_rw();
	mem_pkg::data_t rd;
	mem_pkg::data_t word;
	start_test("public_rw");
	word = $urandom();
	port_access(0, 1'b0, 32'h0000_0100, word, 4'hf, rd);
	port_access(0, 1'b0, 32'h0000_0100, '0, 4'h0, rd);
	compare_word("read data", word, rd);
	if (bus_log.size() != 2) begin
		report_problem("memory did not see exactly two accesses");
	end else begin
		check_addr("write address", 32'h0000_0100, bus_log[0].addr);
		check_addr("read address", 32'h0000_0100, bus_log[1].addr);
	end
	close_test();
endtask

task automatic private_window();
	mem_pkg::data_t rd;
	mem_pkg::data_t word;
	mem_pkg::addr_t win_addr;
	start_test("private_window");
	word = $urandom();
	win_addr = {mem_pkg::PRIV_TAG, 24'h00_0010};
	port_access(1, 1'b0, win_addr, word, 4'hf, rd);
	port_access(1, 1'b0, win_addr, '0, 4'h0, rd);
	compare_word("read data", word, rd);
	if (bus_log.size() != 2) begin
		report_problem("memory did not see exactly two accesses");
	end else begin
		check_addr("write address", PRIV_BASE + PRIV_STRIDE + 32'h10, bus_log[0].addr);
		check_addr("read address", PRIV_BASE + PRIV_STRIDE + 32'h10, bus_log[1].addr);
	end
	close_test();
endtask

task automatic strobe_merge();
	mem_pkg::data_t rd;
	start_test("strobe_merge");
	port_access(0, 1'b0, 32'h0000_0200, 32'hAABB_CCDD, 4'hf, rd);
	port_access(0, 1'b0, 32'h0000_0200, 32'h1122_3344, 4'b0101, rd);
	port_access(0, 1'b0, 32'h0000_0200, '0, 4'h0, rd);
	compare_word("merged word", 32'hAA22_CC44, rd);
	close_test();
endtask

task automatic fetch_priority();
	mem_pkg::data_t rd0;
	mem_pkg::data_t rd1;
	mem_pkg::data_t word0;
	mem_pkg::data_t word1;
	start_test("fetch_priority");
	word0 = $urandom();
	word1 = $urandom();
	mem[word_index(32'h0000_0300)] = word0;
	mem[word_index(32'h0000_0400)] = word1;
	fork
		port_access(0, 1'b0, 32'h0000_0300, '0, 4'h0, rd0);
		port_access(1, 1'b1, 32'h0000_0400, '0, 4'h0, rd1);
	join
	compare_word("port 0 data", word0, rd0);
	compare_word("port 1 data", word1, rd1);
	if (bus_log.size() != 2) begin
		report_problem("memory did not see exactly two accesses");
	end else begin
		check_addr("first bus address", 32'h0000_0400, bus_log[0].addr);
		compare_flag("first bus instr", 1'b1, bus_log[0].instr);
		check_addr("second bus address", 32'h0000_0300, bus_log[1].addr);
		compare_flag("second bus instr", 1'b0, bus_log[1].instr);
	end
	close_test();
endtask

task automatic region_copy();
	mem_pkg::data_t pattern [COPY_WORDS];
	mem_pkg::addr_t offs;
	int waited;
	start_test("region_copy");
	for (int i = 0; i < COPY_WORDS; i++) begin
		pattern[i] = $urandom();
		mem[word_index(PRIV_BASE + mem_pkg::addr_t'(i * mem_pkg::WORD_BYTES))] = pattern[i];
	end
	@(posedge clk);
	copy_req <= 2'b01;
	do @(posedge clk); while (!copy_done[0]);
	// Port 1 never asked for a copy
	compare_flag("copy_done[1]", 1'b0, copy_done[1]);
	for (int i = 0; i < COPY_WORDS; i++) begin
		offs = mem_pkg::addr_t'(i * mem_pkg::WORD_BYTES);
		compare_word($sformatf("word %0d", i), pattern[i],
			mem[word_index(PRIV_BASE + PRIV_STRIDE + offs)]);
	end
	copy_req <= '0;
	waited = 0;
	do begin
		@(posedge clk);
		waited++;
	end while (copy_done[0] && waited < 4);
	if (copy_done[0]) begin
		report_problem("copy_done[0] stayed high after copy_req[0] dropped");
	end
	close_test();
endtask

// File: dv/shared_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module shared_mem_tb;

	localparam int NUM_PORTS = 2;
	localparam mem_pkg::addr_t PRIV_BASE = 32'h0001_0000;
	localparam mem_pkg::addr_t PRIV_STRIDE = 32'h0001_0000;
	localparam mem_pkg::addr_t PRIV_LEN = 32'h0000_0100;
	localparam int SEED = 58590;
	localparam int MEM_AW = 16;
	localparam int MEM_WORDS = 1 << MEM_AW;
	localparam int COPY_WORDS = PRIV_LEN / mem_pkg::WORD_BYTES;

	// About 12 cycles per access at worst; 9 port accesses plus a read and write per copied word
	localparam int ACCESS_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = ACCESS_CYCLES * (9 + 2 * COPY_WORDS) + 100;

	logic clk = 1'b0;
	logic resetn;
	mem_pkg::mem_req_t port_req [NUM_PORTS];
	wire mem_pkg::mem_rsp_t port_rsp [NUM_PORTS];
	logic [NUM_PORTS-1:0] copy_req;
	wire [NUM_PORTS-1:0] copy_done;
	wire mem_pkg::mem_req_t mem_req;
	mem_pkg::mem_rsp_t mem_rsp;

	mem_pkg::data_t mem [MEM_WORDS];
	mem_pkg::mem_req_t bus_log [$];
	int wait_cnt;
	int cycle_count = 0;
	int error_count = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name;

	`include "shared_mem_tests.svh"

	shared_mem_subsys #(
		.NUM_PORTS(NUM_PORTS)
	) i_dut (
		.clk      (clk),
		.resetn   (resetn),
		.port_req (port_req),
		.port_rsp (port_rsp),
		.copy_req (copy_req),
		.copy_done(copy_done),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	always #2 clk = ~clk;

	// Memory answers each access after 0 to 3 wait cycles
	always @(posedge clk) begin : memory_model
		int idx;
		idx = word_index(mem_req.addr);
		if (!resetn) begin
			mem_rsp <= '0;
			wait_cnt <= $urandom_range(3, 0);
		end else if (mem_rsp.ready) begin
			mem_rsp.ready <= 1'b0;
		end else if (mem_req.valid) begin
			if (wait_cnt == 0) begin
				mem_rsp.ready <= 1'b1;
				mem_rsp.rdata <= mem[idx];
				if (mem_req.wstrb != '0) begin
					mem[idx] <= merge_bytes(mem[idx], mem_req.wdata, mem_req.wstrb);
				end
				bus_log.push_back(mem_req);
				wait_cnt <= $urandom_range(3, 0);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		resetn = 1'b0;
		copy_req = '0;
		mem_rsp = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_req[p] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'hC3A5_0000 ^ mem_pkg::data_t'(i * mem_pkg::WORD_BYTES);
		end
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		repeat (2) @(posedge clk);

		public_rw();
		private_window();
		strobe_merge();
		fetch_priority();
		region_copy();

		$display("Summary: %0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
logic/mem_pkg.sv
logic/addr_translator.sv
logic/mem_arbiter.sv
logic/block_mover.sv
logic/copy_scheduler.sv
logic/shared_mem_subsys.sv
dv/shared_mem_tb.sv
